//--- include/fwrisc_macros.svh
`ifndef FWRISC_MACROS_SVH
`define FWRISC_MACROS_SVH

// first fetch address after reset
`define FWRISC_RESET_VECTOR 32'h8000_0000

// machine word width in bits
`define FWRISC_XLEN 32

// architectural integer registers, x0 included
`define FWRISC_NREGS 32

// major opcodes, instr[6:0]
// loads and stores
`define FWRISC_OPC_LOAD   7'b0000011
`define FWRISC_OPC_STORE  7'b0100011

// register-immediate and register-register arithmetic
`define FWRISC_OPC_OP_IMM 7'b0010011
`define FWRISC_OPC_OP     7'b0110011

// control transfer
`define FWRISC_OPC_BRANCH 7'b1100011
`define FWRISC_OPC_JAL    7'b1101111
`define FWRISC_OPC_JALR   7'b1100111

// upper immediate forms
`define FWRISC_OPC_LUI    7'b0110111
`define FWRISC_OPC_AUIPC  7'b0010111

`endif

//--- source/fwrisc_pkg.sv
`include "fwrisc_macros.svh"

package fwrisc_pkg;

	// data or address word
	typedef logic [`FWRISC_XLEN-1:0] word_t;

	// pc without the two low bits, always word aligned
	typedef logic [`FWRISC_XLEN-3:0] pc_t;

	// register index
	typedef logic [$clog2(`FWRISC_NREGS)-1:0] reg_addr_t;

	// one enable per byte lane
	typedef logic [`FWRISC_XLEN/8-1:0] strobe_t;

	// control FSM, one instruction in flight
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMR,
		MEMW
	} state_e;

	// ALU data operations
	typedef enum logic [2:0] {
		ADD,
		SUB,
		XOR,
		OR,
		AND
	} alu_op_e;

	// comparator operations
	typedef enum logic [1:0] {
		EQ,
		LT,
		LTU
	} cmp_op_e;

endpackage

//--- source/fwrisc_decode.sv
`timescale 1ns/1ps
`include "fwrisc_macros.svh"

module fwrisc_decode (
	input  fwrisc_pkg::word_t     instr,
	output logic                  op_load,
	output logic                  op_store,
	output logic                  op_arith_imm,
	output logic                  op_arith_reg,
	output logic                  op_branch,
	output logic                  op_jal,
	output logic                  op_jalr,
	output logic                  op_lui,
	output logic                  op_auipc,
	output fwrisc_pkg::reg_addr_t rs1,
	output fwrisc_pkg::reg_addr_t rs2,
	output fwrisc_pkg::reg_addr_t rd,
	output fwrisc_pkg::word_t     imm,
	output fwrisc_pkg::alu_op_e   alu_op,
	output fwrisc_pkg::cmp_op_e   cmp_op,
	output logic                  branch_invert,
	output logic                  set_less
);
	import fwrisc_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       funct7_ok;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// register fields sit at fixed positions in every format
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// plain ops, or SUB (funct7 0x20) on the add slot only
	assign funct7_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);

	// LB LH LW LBU LHU only
	assign op_load = (opcode == `FWRISC_OPC_LOAD) && (funct3 != 3'b011) &&
		(funct3[2:1] != 2'b11);
	// SB SH SW only
	assign op_store = (opcode == `FWRISC_OPC_STORE) && !funct3[2] && (funct3[1:0] != 2'b11);
	// shifts use funct3 x01 and stay undecoded
	assign op_arith_imm = (opcode == `FWRISC_OPC_OP_IMM) && (funct3[1:0] != 2'b01);
	assign op_arith_reg = (opcode == `FWRISC_OPC_OP) && (funct3[1:0] != 2'b01) && funct7_ok;
	// funct3 010 and 011 are not branches
	assign op_branch = (opcode == `FWRISC_OPC_BRANCH) && (funct3[2:1] != 2'b01);
	assign op_jal    = (opcode == `FWRISC_OPC_JAL);
	assign op_jalr   = (opcode == `FWRISC_OPC_JALR) && (funct3 == 3'b000);
	assign op_lui    = (opcode == `FWRISC_OPC_LUI);
	assign op_auipc  = (opcode == `FWRISC_OPC_AUIPC);

	// immediate forms, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		if (op_store) begin
			imm = imm_s;
		end else if (op_branch) begin
			imm = imm_b;
		end else if (op_lui || op_auipc) begin
			imm = imm_u;
		end else if (op_jal) begin
			imm = imm_j;
		end else begin
			// loads, JALR and OP-IMM
			imm = imm_i;
		end
	end

	// address math and everything else adds
	always_comb begin
		alu_op = ADD;
		if (op_arith_imm || op_arith_reg) begin
			case (funct3)
				3'b000:  alu_op = (op_arith_reg && funct7[5]) ? SUB : ADD;
				3'b100:  alu_op = XOR;
				3'b110:  alu_op = OR;
				3'b111:  alu_op = AND;
				default: alu_op = ADD;
			endcase
		end
	end

	always_comb begin
		if (op_branch) begin
			case (funct3[2:1])
				2'b00:   cmp_op = EQ;
				2'b10:   cmp_op = LT;
				default: cmp_op = LTU;
			endcase
		end else begin
			// SLT(I) vs SLTU/SLTIU
			cmp_op = funct3[0] ? LTU : LT;
		end
	end

	// BNE BGE BGEU take the opposite sense
	assign branch_invert = op_branch && funct3[0];
	assign set_less = (op_arith_imm || op_arith_reg) && (funct3[2:1] == 2'b01);

endmodule

//--- source/fwrisc_alu.sv
`timescale 1ns/1ps

module fwrisc_alu (
	input  fwrisc_pkg::word_t   op_a,
	input  fwrisc_pkg::word_t   op_b,
	input  fwrisc_pkg::alu_op_e op,
	input  fwrisc_pkg::cmp_op_e cmp,
	output fwrisc_pkg::word_t   result,
	output logic                cmp_out
);
	import fwrisc_pkg::*;

	// sum also serves as load/store address and jump target
	always_comb begin
		case (op)
			ADD: begin
				result = op_a + op_b;
			end
			SUB: begin
				result = op_a - op_b;
			end
			XOR: begin
				result = op_a ^ op_b;
			end
			OR: begin
				result = op_a | op_b;
			end
			AND: begin
				result = op_a & op_b;
			end
			default: begin
				result = op_a + op_b;
			end
		endcase
	end

	// same operands as the data path
	// branches feed rs1/rs2 here, SLT forms rs1 and rs2 or imm
	always_comb begin
		case (cmp)
			EQ: begin
				cmp_out = (op_a == op_b);
			end
			LT: begin
				cmp_out = ($signed(op_a) < $signed(op_b));
			end
			default: begin
				// LTU
				cmp_out = (op_a < op_b);
			end
		endcase
	end

endmodule

//--- source/fwrisc_regfile.sv
`timescale 1ns/1ps
`include "fwrisc_macros.svh"

module fwrisc_regfile (
	input  logic                  clock,
	input  logic                  reset,
	input  fwrisc_pkg::reg_addr_t ra_raddr,
	input  fwrisc_pkg::reg_addr_t rb_raddr,
	output fwrisc_pkg::word_t     ra_rdata,
	output fwrisc_pkg::word_t     rb_rdata,
	input  fwrisc_pkg::reg_addr_t rd_waddr,
	input  fwrisc_pkg::word_t     rd_wdata,
	input  logic                  rd_wen
);

	fwrisc_pkg::word_t regs [`FWRISC_NREGS];

	// x0 never written, so it reads zero forever
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `FWRISC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && (rd_waddr != '0)) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

	// registered reads, data one cycle after the address
	always_ff @(posedge clock) begin
		ra_rdata <= regs[ra_raddr];
		rb_rdata <= regs[rb_raddr];
	end

endmodule

//--- source/fwrisc_lsu.sv
`timescale 1ns/1ps

module fwrisc_lsu (
	input  logic [1:0]          addr_low,
	input  logic [1:0]          size,
	input  logic                load_unsigned,
	input  fwrisc_pkg::word_t   store_data,
	input  fwrisc_pkg::word_t   load_raw,
	output fwrisc_pkg::word_t   wdata,
	output fwrisc_pkg::strobe_t strobe,
	output fwrisc_pkg::word_t   load_data
);
	import fwrisc_pkg::*;

	logic [7:0]  load_byte;
	logic [15:0] load_half;

	// store side, data copied to every lane and strobe picks one
	always_comb begin
		case (size)
			2'b00: begin
				wdata  = {4{store_data[7:0]}};
				strobe = strobe_t'(4'b0001 << addr_low);
			end
			2'b01: begin
				// bit 0 ignored for halfwords
				wdata  = {2{store_data[15:0]}};
				strobe = addr_low[1] ? strobe_t'(4'b1100) : strobe_t'(4'b0011);
			end
			default: begin
				wdata  = store_data;
				strobe = strobe_t'(4'b1111);
			end
		endcase
	end

	// load side lane pick
	always_comb begin
		case (addr_low)
			2'b00:   load_byte = load_raw[7:0];
			2'b01:   load_byte = load_raw[15:8];
			2'b10:   load_byte = load_raw[23:16];
			default: load_byte = load_raw[31:24];
		endcase
	end

	assign load_half = addr_low[1] ? load_raw[31:16] : load_raw[15:0];

	// LBU/LHU zero fill, LB/LH copy the top bit
	always_comb begin
		case (size)
			2'b00:   load_data = {{24{!load_unsigned && load_byte[7]}}, load_byte};
			2'b01:   load_data = {{16{!load_unsigned && load_half[15]}}, load_half};
			default: load_data = load_raw;
		endcase
	end

endmodule

//--- source/fwrisc_core.sv
`timescale 1ns/1ps
`include "fwrisc_macros.svh"

module fwrisc_core (
	input  logic                clock,
	input  logic                reset,
	output fwrisc_pkg::word_t   iaddr,
	input  fwrisc_pkg::word_t   idata,
	output logic                ivalid,
	input  logic                iready,
	output fwrisc_pkg::word_t   daddr,
	output fwrisc_pkg::word_t   dwdata,
	input  fwrisc_pkg::word_t   drdata,
	output fwrisc_pkg::strobe_t dstrb,
	output logic                dwrite,
	output logic                dvalid,
	input  logic                dready
);
	import fwrisc_pkg::*;

	state_e    state;
	word_t     instr;
	pc_t       pc;
	pc_t       pc_plus4;
	pc_t       pc_next;
	word_t     branch_target;
	logic      op_load, op_store, op_arith_imm, op_arith_reg, op_branch;
	logic      op_jal, op_jalr, op_lui, op_auipc;
	reg_addr_t rs1, rs2, rd;
	word_t     imm;
	alu_op_e   alu_op;
	cmp_op_e   cmp_op;
	logic      branch_invert, set_less;
	word_t     ra_rdata, rb_rdata, rd_wdata;
	logic      rd_wen;
	logic      writes_rd;
	logic      jump;
	logic      branch_taken;
	word_t     alu_a, alu_b, alu_result;
	logic      cmp_out;
	word_t     load_data;

	assign pc_plus4 = pc + 1'b1;

	// bus outputs come straight from state, stable while valid is held
	assign iaddr  = {pc, 2'b00};
	assign ivalid = (state == FETCH) && !reset;
	assign dvalid = (state == MEMR) || (state == MEMW);
	assign dwrite = (state == MEMW);
	// word address, low bits go to the lane logic
	assign daddr  = {alu_result[31:2], 2'b00};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc    <= pc_t'(`FWRISC_RESET_VECTOR >> 2);
		end else begin
			case (state)
				FETCH: begin
					if (iready) begin
						state <= DECODE;
					end
				end
				// regfile reads rs1/rs2 here
				DECODE: begin
					state <= EXECUTE;
				end
				EXECUTE: begin
					if (op_load) begin
						state <= MEMR;
					end else if (op_store) begin
						state <= MEMW;
					end else begin
						pc    <= pc_next;
						state <= FETCH;
					end
				end
				// wait for the data port
				MEMR, MEMW: begin
					if (dready) begin
						pc    <= pc_next;
						state <= FETCH;
					end
				end
				default: begin
					state <= FETCH;
				end
			endcase
		end
	end

	// instruction register, loaded on fetch accept
	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
	end

	fwrisc_decode u_decode (
		.instr         (instr),
		.op_load       (op_load),
		.op_store      (op_store),
		.op_arith_imm  (op_arith_imm),
		.op_arith_reg  (op_arith_reg),
		.op_branch     (op_branch),
		.op_jal        (op_jal),
		.op_jalr       (op_jalr),
		.op_lui        (op_lui),
		.op_auipc      (op_auipc),
		.rs1           (rs1),
		.rs2           (rs2),
		.rd            (rd),
		.imm           (imm),
		.alu_op        (alu_op),
		.cmp_op        (cmp_op),
		.branch_invert (branch_invert),
		.set_less      (set_less)
	);

	// unsupported opcodes fall out with no write and pc+4
	assign writes_rd = op_lui || op_auipc || op_jal || op_jalr || op_arith_imm || op_arith_reg;
	assign rd_wen = ((state == EXECUTE) && writes_rd) || ((state == MEMR) && dready);

	always_comb begin
		if (state == MEMR) begin
			rd_wdata = load_data;
		end else if (jump) begin
			// link value
			rd_wdata = {pc_plus4, 2'b00};
		end else if (set_less) begin
			rd_wdata = word_t'(cmp_out);
		end else begin
			rd_wdata = alu_result;
		end
	end

	fwrisc_regfile u_regfile (
		.clock    (clock),
		.reset    (reset),
		.ra_raddr (rs1),
		.rb_raddr (rs2),
		.ra_rdata (ra_rdata),
		.rb_rdata (rb_rdata),
		.rd_waddr (rd),
		.rd_wdata (rd_wdata),
		.rd_wen   (rd_wen)
	);

	// operand a is pc, zero for LUI, else rs1
	// operand b is rs2 for OP and branch compares, else the immediate
	always_comb begin
		if (op_lui) begin
			alu_a = '0;
		end else if (op_auipc || op_jal) begin
			alu_a = {pc, 2'b00};
		end else begin
			alu_a = ra_rdata;
		end
		if (op_arith_reg || op_branch) begin
			alu_b = rb_rdata;
		end else begin
			alu_b = imm;
		end
	end

	fwrisc_alu u_alu (
		.op_a    (alu_a),
		.op_b    (alu_b),
		.op      (alu_op),
		.cmp     (cmp_op),
		.result  (alu_result),
		.cmp_out (cmp_out)
	);

	// ALU is busy comparing rs1/rs2 on branches, so the target gets its own adder
	assign branch_target = {pc, 2'b00} + imm;
	assign jump          = op_jal || op_jalr;
	assign branch_taken  = op_branch && (cmp_out ^ branch_invert);

	// JALR bit 0 and any misalignment simply drop off
	always_comb begin
		if (jump) begin
			pc_next = alu_result[31:2];
		end else if (branch_taken) begin
			pc_next = branch_target[31:2];
		end else begin
			pc_next = pc_plus4;
		end
	end

	// funct3 gives size in [13:12] and unsigned in [14]
	fwrisc_lsu u_lsu (
		.addr_low      (alu_result[1:0]),
		.size          (instr[13:12]),
		.load_unsigned (instr[14]),
		.store_data    (rb_rdata),
		.load_raw      (drdata),
		.wdata         (dwdata),
		.strobe        (dstrb),
		.load_data     (load_data)
	);

endmodule

//--- verification/fwrisc_checker.sv
`timescale 1ns/1ps

module fwrisc_checker (
	input  logic                clock,
	input  logic                reset,
	input  fwrisc_pkg::word_t   daddr,
	input  fwrisc_pkg::word_t   dwdata,
	input  fwrisc_pkg::strobe_t dstrb,
	input  logic                dwrite,
	input  logic                dvalid,
	input  logic                dready,
	output int                  pass_count,
	output int                  fail_count,
	output int                  seen_count
);
	import fwrisc_pkg::*;

	// expected stores, in program order
	string   exp_name [$];
	word_t   exp_addr [$];
	word_t   exp_data [$];
	strobe_t exp_strb [$];

	// byte lanes enabled by a strobe, as a bit mask
	function automatic word_t lane_mask(input strobe_t s);
		word_t m;
		m = '0;
		for (int i = 0; i < 4; i++) begin
			if (s[i]) begin
				m[i*8 +: 8] = 8'hff;
			end
		end
		return m;
	endfunction

	function automatic int expected_total();
		return exp_name.size();
	endfunction

	task automatic add_expected(input string name, input word_t addr, input word_t data,
		input strobe_t strb);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	// stores still outstanding when the run is cut short
	task automatic report_missing();
		for (int i = seen_count; i < exp_name.size(); i++) begin
			$display("store for %s at %h never appeared", exp_name[i], exp_addr[i]);
		end
	endtask

	// a store completes when valid, ready and write are all high
	always @(posedge clock) begin
		if (reset) begin
			pass_count <= 0;
			fail_count <= 0;
			seen_count <= 0;
		end else if (dvalid && dready && dwrite) begin
			if (seen_count >= exp_name.size()) begin
				$display("unexpected store beyond the expected list, addr %h data %h",
					daddr, dwdata);
				fail_count <= fail_count + 1;
			end else if (daddr == exp_addr[seen_count] && dstrb == exp_strb[seen_count] &&
				(dwdata & lane_mask(dstrb)) == exp_data[seen_count]) begin
				$display("ok  %s addr=%h data=%h strb=%h", exp_name[seen_count],
					daddr, dwdata & lane_mask(dstrb), dstrb);
				pass_count <= pass_count + 1;
			end else begin
				$display("ERR %s expected addr=%h data=%h strb=%h actual addr=%h data=%h strb=%h",
					exp_name[seen_count], exp_addr[seen_count], exp_data[seen_count],
					exp_strb[seen_count], daddr, dwdata & lane_mask(dstrb), dstrb);
				fail_count <= fail_count + 1;
			end
			seen_count <= seen_count + 1;
		end
	end

endmodule

//--- verification/fwrisc_tb.sv
`timescale 1ns/1ps
`include "fwrisc_macros.svh"

module fwrisc_tb;
	import fwrisc_pkg::*;

	logic    clock;
	logic    reset;
	word_t   iaddr, idata, daddr, dwdata, drdata;
	logic    ivalid, iready, dwrite, dvalid, dready;
	strobe_t dstrb;
	int      pass_count, fail_count, seen_count;
	word_t   imem [64];
	word_t   dmem [256];
	int      prog_len;
	int      exp_total;
	int      iwait, dwait;
	logic    loaded;

	fwrisc_core dut_i (
		.clock (clock), .reset (reset),
		.iaddr (iaddr), .idata (idata), .ivalid (ivalid), .iready (iready),
		.daddr (daddr), .dwdata (dwdata), .drdata (drdata), .dstrb (dstrb),
		.dwrite (dwrite), .dvalid (dvalid), .dready (dready)
	);

	fwrisc_checker checker_i (
		.clock (clock), .reset (reset), .daddr (daddr), .dwdata (dwdata),
		.dstrb (dstrb), .dwrite (dwrite), .dvalid (dvalid), .dready (dready),
		.pass_count (pass_count), .fail_count (fail_count), .seen_count (seen_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// P program word, D data word, E named expected store
	task automatic load_patterns();
		int    fd;
		string line, kind, name;
		word_t a, d, s;
		fd = $fopen("verification/fwrisc_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the patterns file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			kind = "";
			if ($sscanf(line, "%s", kind) != 1 || kind == "#") begin
				continue;
			end
			if (kind == "P" && $sscanf(line, "%s %h", kind, d) == 2) begin
				imem[prog_len] = d;
				prog_len++;
			end else if (kind == "D" && $sscanf(line, "%s %h %h", kind, a, d) == 3) begin
				dmem[a[9:2]] = d;
			end else if (kind == "E" &&
				$sscanf(line, "%s %s %h %h %h", kind, name, a, d, s) == 5) begin
				checker_i.add_expected(name, a, d, s[3:0]);
			end
		end
		$fclose(fd);
	endtask

	// instruction memory answers after 0 to 3 idle cycles
	always @(posedge clock) begin
		#1;
		if (iready) begin
			iready = 1'b0;
		end else if (ivalid && !reset) begin
			if (iwait == 0) begin
				idata  = imem[(iaddr - `FWRISC_RESET_VECTOR) >> 2];
				iready = 1'b1;
				iwait  = $urandom % 4;
			end else begin
				iwait--;
			end
		end
	end

	// data memory merges stores under the strobe
	always @(posedge clock) begin
		#1;
		if (dready) begin
			dready = 1'b0;
		end else if (dvalid && !reset) begin
			if (dwait == 0) begin
				if (dwrite) begin
					for (int i = 0; i < 4; i++) begin
						if (dstrb[i]) begin
							dmem[daddr[9:2]][i*8 +: 8] = dwdata[i*8 +: 8];
						end
					end
				end
				drdata = dmem[daddr[9:2]];
				dready = 1'b1;
				dwait  = $urandom % 4;
			end else begin
				dwait--;
			end
		end
	end

	// watchdog allows length x 4 x (5 + 3) x 2 clock periods
	initial begin
		wait (loaded);
		#(prog_len * 4 * 8 * 2 * 20);
		$display("timeout: %0d of %0d stores seen", seen_count, checker_i.expected_total());
		checker_i.report_missing();
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		reset     = 1'b1;
		idata     = '0;
		iready    = 1'b0;
		drdata    = '0;
		dready    = 1'b0;
		prog_len  = 0;
		exp_total = 0;
		loaded    = 1'b0;
		void'($urandom(74));
		iwait     = $urandom % 4;
		dwait     = $urandom % 4;
		for (int i = 0; i < 256; i++) begin
			// background words differ at every index
			dmem[i] = {8'hd0, 14'(i), 10'(i * 3)};
		end
		load_patterns();
		exp_total = checker_i.expected_total();
		loaded    = 1'b1;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		wait (seen_count >= exp_total);
		// stay a while so a stray store would be caught
		repeat (40) @(posedge clock);
		$display("stores: %0d pass, %0d fail, %0d expected", pass_count, fail_count,
			exp_total);
		if (fail_count == 0 && pass_count == exp_total && pass_count > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- verification/fwrisc_patterns.txt
# P word: program from the reset vector   D addr data: initial data word
# E name addr data strobe: expected store, data masked by the strobe
D 00000010 80FF7F01
P 123450B7
P 67808093
P 00102023
P FFF00113
P 402081B3
P 00302223
P 00012233
P 000132B3
P 00402423
P 00502623
P 01300303
P 01205383
P 00602A23
P 00702C23
P 00100EA3
P 00500013
P 02002023
P 00000463
P 02102223
P 0080046F
P 02102423
P 02802623
P 0000000F
P 02302823
P 0000006F
E lui_addi 00000000 12345678 F
E sub 00000004 12345679 F
E slt 00000008 00000001 F
E sltu 0000000C 00000000 F
E lb_sign 00000014 FFFFFF80 F
E lhu_zero 00000018 000080FF F
E sb_lane1 0000001C 00007800 2
E x0_zero 00000020 00000000 F
E beq_jal_link 0000002C 80000050 F
E unsupported 00000030 12345679 F

//--- sources.f
+incdir+include
source/fwrisc_pkg.sv
source/fwrisc_decode.sv
source/fwrisc_alu.sv
source/fwrisc_regfile.sv
source/fwrisc_lsu.sv
source/fwrisc_core.sv
verification/fwrisc_checker.sv
verification/fwrisc_tb.sv
